/* bench/core_demux_testdata.txt */
// cluster_id wen addr wdata be rdata opc  (all hex, wen 1 = read)
// Target follows from addr[31:20] against the cluster base 0x100 + 4 * cluster_id
00 1 10000010 00000000 f 1234abcd 0
00 0 10000024 cafef00d 3 00000000 0
00 1 10100008 00000000 f 5a5a0001 1  // TCDM test-and-set, opc must read 0
00 1 10204000 00000000 f e0e0e0e0 1
00 0 10207ffc 0badf00d c 00000000 0
00 1 10200100 00000000 f 0f0f0f0f 0
00 0 10203ff8 11223344 1 00000000 1
00 1 10300000 00000000 f 33330000 0
00 1 1a100000 00000000 f 87654321 0
03 1 10c00040 00000000 f 76543210 0
03 0 10d00000 a5a5a5a5 f 00000000 0
03 1 10e04004 00000000 f 44556677 0
03 1 10e00004 00000000 f 99887766 1
03 1 10000000 00000000 f 01010101 0  // Cluster 0 TCDM seen from cluster 3
03 0 10204000 deadbeef f 00000000 0
01 1 10400000 00000000 f 13572468 0
01 1 10604000 00000000 f 24681357 1
01 0 10c00000 55aa55aa 6 00000000 0
3f 1 1fc00000 00000000 f 0000ffff 0
3f 0 1fd00010 abcdef01 8 00000000 0
3f 1 1fe04000 00000000 f ffff0000 0
3f 1 1fe00000 00000000 f 10203040 1
3f 1 1ff00000 00000000 f 50607080 0
2a 0 1a800000 76767676 f 00000000 0
00 1 1a800000 00000000 f 89abcdef 0
2a 1 1aa04000 00000000 f fedcba98 1
00 0 00000000 31415926 f 00000000 0
00 1 ffffc000 00000000 f 27182818 0

/* bench/tb_core_demux.sv */
// Testbench for the core data demux with target port models and file-driven transactions
`default_nettype none

// Target port that grants after delay_i wait cycles and replies one cycle after the grant
module target_model (
  input  wire logic        clk,
  input  wire logic        rst_ni,
  input  wire logic        req_i,
  input  wire logic [1:0]  delay_i,
  input  wire logic [31:0] reply_rdata_i,
  input  wire logic        reply_opc_i,
  output logic             gnt_o,
  output logic             r_valid_o,
  output logic [31:0]      r_rdata_o,
  output logic             r_opc_o
);

  logic [1:0]  wait_q  = 2'd0;
  logic        valid_q = 1'b0;
  logic [31:0] rdata_q = 32'd0;
  logic        opc_q   = 1'b0;

  assign gnt_o     = req_i && (wait_q == delay_i);
  assign r_valid_o = valid_q;
  assign r_rdata_o = rdata_q;
  assign r_opc_o   = opc_q;

  always @(posedge clk, negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      wait_q  <= 2'd0;
      valid_q <= 1'b0;
    end
    else
    begin
      valid_q <= gnt_o;  // One-cycle reply pulse
      if (gnt_o)
      begin
        wait_q  <= 2'd0;
        rdata_q <= reply_rdata_i;
        opc_q   <= reply_opc_i;
      end
      else if (req_i)
      begin
        wait_q <= wait_q + 2'd1;
      end
    end
  end

endmodule

module tb_core_demux;

  localparam int T_SH    = 0;
  localparam int T_PE    = 1;
  localparam int T_EXT   = 2;
  localparam int MAX_TXN = 64;
  localparam int TIMEOUT = 40;  // Cycles per wait loop

  logic        clk    = 1'b0;
  logic        rst_ni = 1'b0;
  logic        data_req;
  logic [31:0] data_add;
  logic        data_wen;
  logic [31:0] data_wdata;
  logic [3:0]  data_be;
  logic [5:0]  cluster_id;
  logic [1:0]  gnt_delay;
  logic [31:0] reply_rdata;
  logic        reply_opc;

  logic        data_gnt, data_r_valid, data_r_opc;
  logic [31:0] data_r_rdata;
  logic        sh_req, sh_wen, sh_gnt, sh_r_valid;
  logic [31:0] sh_addr, sh_wdata, sh_r_rdata;
  logic [3:0]  sh_be;
  logic        ext_req, ext_wen, ext_gnt, ext_r_valid, ext_r_opc;
  logic [31:0] ext_addr, ext_wdata, ext_r_rdata;
  logic [3:0]  ext_be;
  logic        pe_req, pe_wen, pe_gnt, pe_r_valid, pe_r_opc;
  logic [31:0] pe_addr, pe_wdata, pe_r_rdata;
  logic [3:0]  pe_be;
  logic        perf_ld, perf_st, perf_ld_cyc, perf_st_cyc;

  logic [31:0] testdata [0:7*MAX_TXN-1];  // Seven columns per transaction
  int          cycle_cnt = 0;
  int          errors    = 0;
  bit          timed_out = 1'b0;

  always #4 clk = ~clk;

  always @(posedge clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
  end

  // ****************************************
  // DUT and target models
  // ****************************************
  core_demux #(
    .DATA_WIDTH (32)
  ) core_demux_i (
    .clk              (clk),
    .rst_ni           (rst_ni),
    .data_req_i       (data_req),
    .data_add_i       (data_add),
    .data_wen_i       (data_wen),
    .data_wdata_i     (data_wdata),
    .data_be_i        (data_be),
    .data_gnt_o       (data_gnt),
    .data_r_valid_o   (data_r_valid),
    .data_r_rdata_o   (data_r_rdata),
    .data_r_opc_o     (data_r_opc),
    .sh_req_o         (sh_req),
    .sh_addr_o        (sh_addr),
    .sh_wen_o         (sh_wen),
    .sh_wdata_o       (sh_wdata),
    .sh_be_o          (sh_be),
    .sh_gnt_i         (sh_gnt),
    .sh_r_valid_i     (sh_r_valid),
    .sh_r_rdata_i     (sh_r_rdata),
    .ext_req_o        (ext_req),
    .ext_addr_o       (ext_addr),
    .ext_wen_o        (ext_wen),
    .ext_wdata_o      (ext_wdata),
    .ext_be_o         (ext_be),
    .ext_gnt_i        (ext_gnt),
    .ext_r_valid_i    (ext_r_valid),
    .ext_r_opc_i      (ext_r_opc),
    .ext_r_rdata_i    (ext_r_rdata),
    .pe_req_o         (pe_req),
    .pe_addr_o        (pe_addr),
    .pe_wen_o         (pe_wen),
    .pe_wdata_o       (pe_wdata),
    .pe_be_o          (pe_be),
    .pe_gnt_i         (pe_gnt),
    .pe_r_valid_i     (pe_r_valid),
    .pe_r_opc_i       (pe_r_opc),
    .pe_r_rdata_i     (pe_r_rdata),
    .perf_l2_ld_o     (perf_ld),
    .perf_l2_st_o     (perf_st),
    .perf_l2_ld_cyc_o (perf_ld_cyc),
    .perf_l2_st_cyc_o (perf_st_cyc),
    .cluster_id_i     (cluster_id)
  );

  target_model sh_model (
    .clk (clk), .rst_ni (rst_ni), .req_i (sh_req), .delay_i (gnt_delay),
    .reply_rdata_i (reply_rdata), .reply_opc_i (reply_opc),
    .gnt_o (sh_gnt), .r_valid_o (sh_r_valid), .r_rdata_o (sh_r_rdata), .r_opc_o ()
  );

  target_model ext_model (
    .clk (clk), .rst_ni (rst_ni), .req_i (ext_req), .delay_i (gnt_delay),
    .reply_rdata_i (reply_rdata), .reply_opc_i (reply_opc),
    .gnt_o (ext_gnt), .r_valid_o (ext_r_valid), .r_rdata_o (ext_r_rdata), .r_opc_o (ext_r_opc)
  );

  target_model pe_model (
    .clk (clk), .rst_ni (rst_ni), .req_i (pe_req), .delay_i (gnt_delay),
    .reply_rdata_i (reply_rdata), .reply_opc_i (reply_opc),
    .gnt_o (pe_gnt), .r_valid_o (pe_r_valid), .r_rdata_o (pe_r_rdata), .r_opc_o (pe_r_opc)
  );

  // ****************************************
  // Reference decode and helpers
  // ****************************************
  function automatic int expected_target(input logic [5:0] cid, input logic [31:0] addr);
    logic [11:0] first;
    logic [11:0] region;
    first  = 12'h100 + {4'd0, cid, 2'b00};  // Four regions per cluster
    region = addr[31:20];
    if (region == first || region == first + 12'd1)
      return T_SH;
    else if (region == first + 12'd2)
      return addr[14] ? T_EXT : T_PE;
    return T_PE;
  endfunction

  function automatic bit fields_match(input int tgt, input logic wen, input logic [31:0] addr,
                                      input logic [31:0] wdata, input logic [3:0] be);
    case (tgt)
      T_SH:    return sh_addr === addr && sh_wen === wen && sh_wdata === wdata && sh_be === be;
      T_EXT:   return ext_addr === addr && ext_wen === wen && ext_wdata === wdata
                      && ext_be === be;
      default: return pe_addr === addr && pe_wen === wen && pe_wdata === wdata && pe_be === be;
    endcase
  endfunction

  task automatic report_mismatch(input string msg);
    $display("ERR %0t: %s", $time, msg);
    errors++;
  endtask

  task automatic check_reset(output bit ok);
    int err_start;
    err_start = errors;
    if ({sh_req, ext_req, pe_req, data_gnt, data_r_valid} !== 5'b0)
      report_mismatch("request, grant or response high after reset");
    if ({perf_ld, perf_st, perf_ld_cyc, perf_st_cyc} !== 4'b0)
      report_mismatch("perf pulse high after reset");
    ok = (errors == err_start);
  endtask

  // ****************************************
  // One transaction from the data file
  // ****************************************
  task automatic run_txn(input int idx, output bit ok);
    logic [5:0]  cid;
    logic        wen;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  be;
    logic [31:0] rdata;
    logic        opc;
    int          tgt;
    int          cycles;
    int          err_start;
    int          pe_rv_cycle;
    int          gnt_cycle;
    bit          l2;
    bit          exp_gnt;
    bit          granted;
    bit          pe_fwd_done;
    bit          responded;

    cid         = testdata[idx*7][5:0];
    wen         = testdata[idx*7+1][0];
    addr        = testdata[idx*7+2];
    wdata       = testdata[idx*7+3];
    be          = testdata[idx*7+4][3:0];
    rdata       = testdata[idx*7+5];
    opc         = testdata[idx*7+6][0];
    tgt         = expected_target(cid, addr);
    l2          = (tgt != T_SH);
    err_start   = errors;
    pe_rv_cycle = -10;
    pe_fwd_done = 1'b0;
    granted     = 1'b0;
    responded   = 1'b0;
    cycles      = 0;

    @(posedge clk);
    cluster_id  <= cid;
    data_add    <= addr;
    data_wen    <= wen;
    data_wdata  <= wdata;
    data_be     <= be;
    data_req    <= 1'b1;
    gnt_delay   <= 2'($urandom % 4);
    reply_rdata <= rdata;
    reply_opc   <= opc;

    while (!granted && cycles < TIMEOUT)
    begin
      @(negedge clk);
      cycles++;
      case (tgt)
        T_SH:    exp_gnt = (sh_gnt === 1'b1);
        T_EXT:   exp_gnt = (ext_gnt === 1'b1);
        default: exp_gnt = (cycle_cnt == pe_rv_cycle + 1);  // One cycle after the PE reply
      endcase
      if (sh_req !== (tgt == T_SH) || ext_req !== (tgt == T_EXT)
          || pe_req !== (tgt == T_PE && !pe_fwd_done))
        report_mismatch($sformatf("txn %0d request on wrong port sh=%b pe=%b ext=%b",
                                  idx, sh_req, pe_req, ext_req));
      if (!fields_match(tgt, wen, addr, wdata, be))
        report_mismatch($sformatf("txn %0d request fields changed at the port", idx));
      if (data_gnt !== exp_gnt)
        report_mismatch($sformatf("txn %0d core grant %b, expected %b", idx, data_gnt,
                                  exp_gnt));
      if (perf_ld_cyc !== (l2 && wen) || perf_st_cyc !== (l2 && !wen))
        report_mismatch($sformatf("txn %0d cycle pulses ld=%b st=%b", idx, perf_ld_cyc,
                                  perf_st_cyc));
      if (perf_ld !== (l2 && wen && exp_gnt) || perf_st !== (l2 && !wen && exp_gnt))
        report_mismatch($sformatf("txn %0d grant pulses ld=%b st=%b", idx, perf_ld, perf_st));
      if (data_r_valid !== 1'b0)
        report_mismatch($sformatf("txn %0d response before grant", idx));
      if (pe_r_valid === 1'b1)
        pe_rv_cycle = cycle_cnt;
      if (pe_gnt === 1'b1)
        pe_fwd_done = 1'b1;  // Sequencer leaves IDLE
      granted   = (data_gnt === 1'b1);
      gnt_cycle = cycle_cnt;
    end

    @(posedge clk);
    data_req <= 1'b0;
    cycles = 0;
    while (granted && !responded && cycles < TIMEOUT)
    begin
      @(negedge clk);
      cycles++;
      if ({perf_ld, perf_st, perf_ld_cyc, perf_st_cyc} !== 4'b0)
        report_mismatch($sformatf("txn %0d perf pulse without request", idx));
      responded = (data_r_valid === 1'b1);
    end

    if (!granted || !responded)
    begin
      $display("Timeout: transaction %0d got no %s", idx, granted ? "response" : "grant");
      timed_out = 1'b1;
    end
    else
    begin
      if (cycle_cnt != gnt_cycle + 1)
        report_mismatch($sformatf("txn %0d response not in the cycle after the grant", idx));
      if (data_r_rdata !== rdata || data_r_opc !== (l2 ? opc : 1'b0))
        report_mismatch($sformatf("txn %0d response %h/%b, expected %h/%b", idx, data_r_rdata,
                                  data_r_opc, rdata, l2 ? opc : 1'b0));
    end
    ok = !timed_out && (errors == err_start);
  endtask

  // ****************************************
  // Main sequence
  // ****************************************
  initial
  begin
    int n_txn;
    int passed;
    int failed;
    bit ok;

    void'($urandom(32'h8d27_4587));
    data_req    = 1'b0;
    data_add    = 32'd0;
    data_wen    = 1'b1;
    data_wdata  = 32'd0;
    data_be     = 4'd0;
    cluster_id  = 6'd0;
    gnt_delay   = 2'd0;
    reply_rdata = 32'd0;
    reply_opc   = 1'b0;
    passed      = 0;
    failed      = 0;
    n_txn       = 0;

    $readmemh("bench/core_demux_testdata.txt", testdata);
    while (n_txn < MAX_TXN && !$isunknown(testdata[n_txn*7]))
      n_txn++;
    if (n_txn == 0)
    begin
      $display("No transactions could be read from the test data file");
      failed++;
    end

    repeat (10) @(posedge clk);
    rst_ni <= 1'b1;
    @(negedge clk);
    check_reset(ok);
    $display("reset: %s", ok ? "ok" : "FAILED");
    if (ok)
      passed++;
    else
      failed++;

    for (int i = 0; i < n_txn && !timed_out; i++)
    begin
      run_txn(i, ok);
      $display("txn %0d: %s", i, ok ? "ok" : "FAILED");
      if (ok)
        passed++;
      else
        failed++;
    end

    $display("%0d tests run, %0d ok, %0d with errors, %0d error lines", passed + failed,
             passed, failed, errors);
    if (failed == 0 && errors == 0 && !timed_out)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

/* hw/addr_decoder.sv */
// Address decoder that maps a core data address onto its target port
`default_nettype none

module addr_decoder
  import core_demux_pkg::*;
(
  input  wire addr_t       addr_i,
  input  wire cluster_id_t cluster_id_i,
  output dest_e            dest_o
);

  region_t addr_region;
  region_t cluster_base;
  region_t tcdm_rw_region;
  region_t tcdm_ts_region;
  region_t dem_per_region;

  assign addr_region = addr_i[ADDR_WIDTH-1:REGION_LSB];

  // ****************************************
  // Cluster regions
  // ****************************************

  // The cluster block moves by four regions per cluster ID
  assign cluster_base = CLUSTER_REGION_BASE
                      + region_t'(cluster_id_i) * REGIONS_PER_CLUSTER;

  assign tcdm_rw_region = cluster_base + TCDM_RW_OFS;
  assign tcdm_ts_region = cluster_base + TCDM_TS_OFS;
  assign dem_per_region = cluster_base + DEM_PER_OFS;

  // ****************************************
  // Destination
  // ****************************************
  always_comb
  begin
    if ((addr_region == tcdm_rw_region) || (addr_region == tcdm_ts_region))
    begin
      dest_o = SH;  // Both TCDM views
    end
    else if (addr_region == dem_per_region)
    begin
      // Upper half of the demux peripheral region sits outside the cluster bus
      if (addr_i[EXT_SELECT_BIT])
      begin
        dest_o = EXT;
      end
      else
      begin
        dest_o = PE;
      end
    end
    else
    begin
      dest_o = PE;  // Cluster peripherals and the rest of the map
    end
  end

endmodule

`default_nettype wire

/* hw/core_demux.sv */
// Data-side demux of a core towards the cluster TCDM, external and peripheral ports
`default_nettype none

module core_demux
  import core_demux_pkg::*;
#(
  parameter int unsigned  DATA_WIDTH = DATA_WIDTH_DEFAULT,
  localparam int unsigned BE_WIDTH   = DATA_WIDTH / 8
)
(
  input  wire logic                  clk,
  input  wire logic                  rst_ni,

  // Core side
  input  wire logic                  data_req_i,
  input  wire addr_t                 data_add_i,
  input  wire logic                  data_wen_i,
  input  wire logic [DATA_WIDTH-1:0] data_wdata_i,
  input  wire logic [BE_WIDTH-1:0]   data_be_i,
  output logic                       data_gnt_o,
  output logic                       data_r_valid_o,
  output logic [DATA_WIDTH-1:0]      data_r_rdata_o,
  output logic                       data_r_opc_o,

  // Shared TCDM port
  output logic                       sh_req_o,
  output addr_t                      sh_addr_o,
  output logic                       sh_wen_o,
  output logic [DATA_WIDTH-1:0]      sh_wdata_o,
  output logic [BE_WIDTH-1:0]        sh_be_o,
  input  wire logic                  sh_gnt_i,
  input  wire logic                  sh_r_valid_i,
  input  wire logic [DATA_WIDTH-1:0] sh_r_rdata_i,

  // External demux peripheral port
  output logic                       ext_req_o,
  output addr_t                      ext_addr_o,
  output logic                       ext_wen_o,
  output logic [DATA_WIDTH-1:0]      ext_wdata_o,
  output logic [BE_WIDTH-1:0]        ext_be_o,
  input  wire logic                  ext_gnt_i,
  input  wire logic                  ext_r_valid_i,
  input  wire logic                  ext_r_opc_i,
  input  wire logic [DATA_WIDTH-1:0] ext_r_rdata_i,

  // Peripheral interconnect port
  output logic                       pe_req_o,
  output addr_t                      pe_addr_o,
  output logic                       pe_wen_o,
  output logic [DATA_WIDTH-1:0]      pe_wdata_o,
  output logic [BE_WIDTH-1:0]        pe_be_o,
  input  wire logic                  pe_gnt_i,
  input  wire logic                  pe_r_valid_i,
  input  wire logic                  pe_r_opc_i,
  input  wire logic [DATA_WIDTH-1:0] pe_r_rdata_i,

  // Performance pulses
  output logic                       perf_l2_ld_o,
  output logic                       perf_l2_st_o,
  output logic                       perf_l2_ld_cyc_o,
  output logic                       perf_l2_st_cyc_o,

  input  wire cluster_id_t           cluster_id_i
);

  dest_e                 dest;
  logic                  periph_req;      // Router to sequencer
  logic                  periph_gnt;      // Sequencer back to router
  logic                  periph_r_valid;
  logic                  periph_r_opc;
  logic [DATA_WIDTH-1:0] periph_r_rdata;

  // ****************************************
  // Request fields shared by all ports
  // ****************************************
  assign sh_addr_o   = data_add_i;
  assign sh_wen_o    = data_wen_i;
  assign sh_wdata_o  = data_wdata_i;
  assign sh_be_o     = data_be_i;

  assign ext_addr_o  = data_add_i;
  assign ext_wen_o   = data_wen_i;
  assign ext_wdata_o = data_wdata_i;
  assign ext_be_o    = data_be_i;

  assign pe_addr_o   = data_add_i;
  assign pe_wen_o    = data_wen_i;
  assign pe_wdata_o  = data_wdata_i;
  assign pe_be_o     = data_be_i;

  // ****************************************
  // Decode, routing and sequencing
  // ****************************************
  addr_decoder addr_decoder_i (
    .addr_i       (data_add_i),
    .cluster_id_i (cluster_id_i),
    .dest_o       (dest)
  );

  req_router req_router_i (
    .data_req_i       (data_req_i),
    .data_wen_i       (data_wen_i),
    .dest_i           (dest),
    .data_gnt_o       (data_gnt_o),
    .sh_req_o         (sh_req_o),
    .sh_gnt_i         (sh_gnt_i),
    .ext_req_o        (ext_req_o),
    .ext_gnt_i        (ext_gnt_i),
    .pe_req_o         (periph_req),
    .pe_gnt_i         (periph_gnt),
    .perf_l2_ld_o     (perf_l2_ld_o),
    .perf_l2_st_o     (perf_l2_st_o),
    .perf_l2_ld_cyc_o (perf_l2_ld_cyc_o),
    .perf_l2_st_cyc_o (perf_l2_st_cyc_o)
  );

  periph_txn_fsm #(
    .DATA_WIDTH (DATA_WIDTH)
  ) periph_txn_fsm_i (
    .clk          (clk),
    .rst_ni       (rst_ni),
    .req_i        (periph_req),
    .gnt_o        (periph_gnt),
    .pe_req_o     (pe_req_o),
    .pe_gnt_i     (pe_gnt_i),
    .pe_r_valid_i (pe_r_valid_i),
    .pe_r_opc_i   (pe_r_opc_i),
    .pe_r_rdata_i (pe_r_rdata_i),
    .r_valid_o    (periph_r_valid),
    .r_opc_o      (periph_r_opc),
    .r_rdata_o    (periph_r_rdata)
  );

  // ****************************************
  // Response path
  // ****************************************
  resp_select #(
    .DATA_WIDTH (DATA_WIDTH)
  ) resp_select_i (
    .clk            (clk),
    .rst_ni         (rst_ni),
    .data_req_i     (data_req_i),
    .dest_i         (dest),
    .sh_r_valid_i   (sh_r_valid_i),
    .sh_r_rdata_i   (sh_r_rdata_i),
    .ext_r_valid_i  (ext_r_valid_i),
    .ext_r_opc_i    (ext_r_opc_i),
    .ext_r_rdata_i  (ext_r_rdata_i),
    .pe_r_valid_i   (periph_r_valid),
    .pe_r_opc_i     (periph_r_opc),
    .pe_r_rdata_i   (periph_r_rdata),
    .data_r_valid_o (data_r_valid_o),
    .data_r_opc_o   (data_r_opc_o),
    .data_r_rdata_o (data_r_rdata_o)
  );

endmodule

`default_nettype wire

/* hw/core_demux_pkg.sv */
// Shared address map, width types and target encoding of the core data demux
`default_nettype none

package core_demux_pkg;

  // ****************************************
  // Widths
  // ****************************************
  localparam int unsigned ADDR_WIDTH         = 32;  // Fixed by the memory map
  localparam int unsigned REGION_LSB         = 20;  // Region field is addr[31:20]
  localparam int unsigned CLUSTER_ID_WIDTH   = 6;
  localparam int unsigned DATA_WIDTH_DEFAULT = 32;

  typedef logic [ADDR_WIDTH-1:0]            addr_t;
  typedef logic [ADDR_WIDTH-REGION_LSB-1:0] region_t;
  typedef logic [CLUSTER_ID_WIDTH-1:0]      cluster_id_t;

  // ****************************************
  // Memory map
  // ****************************************
  localparam region_t CLUSTER_REGION_BASE = 12'h100;  // First region of cluster 0
  localparam region_t REGIONS_PER_CLUSTER = 12'd4;

  // Offsets from the first region of a cluster
  localparam region_t TCDM_RW_OFS = 12'd0;  // TCDM read/write
  localparam region_t TCDM_TS_OFS = 12'd1;  // TCDM test-and-set
  localparam region_t DEM_PER_OFS = 12'd2;  // Demux peripherals

  // Inside the demux peripheral region this bit picks the external port
  localparam int unsigned EXT_SELECT_BIT = 14;

  // ****************************************
  // Target encoding
  // ****************************************
  typedef enum logic [1:0] {
    SH,   // Shared TCDM side
    PE,   // Peripheral interconnect
    EXT   // External demux peripherals
  } dest_e;

endpackage

`default_nettype wire

/* hw/periph_txn_fsm.sv */
// Peripheral transaction sequencer with a two-stage response delay
`default_nettype none

module periph_txn_fsm
  import core_demux_pkg::*;
#(
  parameter int unsigned DATA_WIDTH = DATA_WIDTH_DEFAULT
)
(
  input  wire logic                  clk,
  input  wire logic                  rst_ni,

  // Router side
  input  wire logic                  req_i,
  output logic                       gnt_o,

  // Peripheral interconnect
  output logic                       pe_req_o,
  input  wire logic                  pe_gnt_i,
  input  wire logic                  pe_r_valid_i,
  input  wire logic                  pe_r_opc_i,
  input  wire logic [DATA_WIDTH-1:0] pe_r_rdata_i,

  // Delayed response towards the core
  output logic                       r_valid_o,
  output logic                       r_opc_o,
  output logic [DATA_WIDTH-1:0]      r_rdata_o
);

  typedef enum logic [1:0] {
    IDLE,
    PENDING,
    GRANTED
  } state_e;

  state_e state_q;
  state_e state_d;

  logic                  valid_s1_q;
  logic                  opc_s1_q;
  logic [DATA_WIDTH-1:0] rdata_s1_q;

  // ****************************************
  // Transaction sequencer
  // ****************************************
  always_ff @(posedge clk, negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      state_q <= IDLE;
    end
    else
    begin
      state_q <= state_d;
    end
  end

  always_comb
  begin
    state_d  = state_q;
    pe_req_o = 1'b0;
    gnt_o    = 1'b0;

    case (state_q)
      IDLE:
      begin
        pe_req_o = req_i;  // Forwarded in the cycle of the core request
        if (req_i && pe_gnt_i)
        begin
          state_d = PENDING;
        end
      end

      PENDING:
      begin
        if (pe_r_valid_i)
        begin
          state_d = GRANTED;
        end
      end

      GRANTED:
      begin
        gnt_o   = 1'b1;  // Core sees its grant only once the peripheral answered
        state_d = IDLE;
      end

      default: state_d = IDLE;
    endcase
  end

  // ****************************************
  // Response pipeline
  // ****************************************
  always_ff @(posedge clk, negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      valid_s1_q <= 1'b0;
      r_valid_o  <= 1'b0;
    end
    else
    begin
      valid_s1_q <= pe_r_valid_i;
      r_valid_o  <= valid_s1_q;
    end
  end

  always_ff @(posedge clk)
  begin
    if (pe_r_valid_i)
    begin
      rdata_s1_q <= pe_r_rdata_i;
      opc_s1_q   <= pe_r_opc_i;
    end
    if (valid_s1_q)
    begin
      r_rdata_o <= rdata_s1_q;
      r_opc_o   <= opc_s1_q;
    end
  end

  // A peripheral reply only comes while the sequencer waits for it
  reply_when_pending_a: assert property (@(posedge clk) disable iff (!rst_ni)
    pe_r_valid_i |-> (state_q == PENDING))
    else $error("periph_txn_fsm: peripheral reply outside PENDING");

endmodule

`default_nettype wire

/* hw/req_router.sv */
// Request router that steers the core request to one target and returns its grant
`default_nettype none

module req_router
  import core_demux_pkg::*;
(
  // Core side
  input  wire logic  data_req_i,
  input  wire logic  data_wen_i,   // 1 for a read
  input  wire dest_e dest_i,
  output logic       data_gnt_o,

  // Shared TCDM port
  output logic       sh_req_o,
  input  wire logic  sh_gnt_i,

  // External port
  output logic       ext_req_o,
  input  wire logic  ext_gnt_i,

  // Peripheral sequencer
  output logic       pe_req_o,
  input  wire logic  pe_gnt_i,

  // Performance pulses
  output logic       perf_l2_ld_o,      // Granted L2 load
  output logic       perf_l2_st_o,      // Granted L2 store
  output logic       perf_l2_ld_cyc_o,  // Cycle spent on an L2 load
  output logic       perf_l2_st_cyc_o   // Cycle spent on an L2 store
);

  logic l2_req;
  logic path_gnt;

  // ****************************************
  // Request steering
  // ****************************************
  assign sh_req_o  = data_req_i && (dest_i == SH);
  assign ext_req_o = data_req_i && (dest_i == EXT);
  assign pe_req_o  = data_req_i && (dest_i == PE);

  always_comb
  begin
    case (dest_i)
      SH:      path_gnt = sh_gnt_i;
      EXT:     path_gnt = ext_gnt_i;
      PE:      path_gnt = pe_gnt_i;
      default: path_gnt = 1'b0;
    endcase
  end

  assign data_gnt_o = data_req_i & path_gnt;

  // ****************************************
  // L2 performance pulses
  // ****************************************

  // Anything that leaves the cluster TCDM counts as L2 traffic
  assign l2_req = data_req_i && (dest_i != SH);

  assign perf_l2_ld_o     = l2_req & data_gnt_o & data_wen_i;
  assign perf_l2_st_o     = l2_req & data_gnt_o & ~data_wen_i;
  assign perf_l2_ld_cyc_o = l2_req & data_wen_i;
  assign perf_l2_st_cyc_o = l2_req & ~data_wen_i;

endmodule

`default_nettype wire

/* hw/resp_select.sv */
// Response multiplexer that follows the destination of the last core request
`default_nettype none

module resp_select
  import core_demux_pkg::*;
#(
  parameter int unsigned DATA_WIDTH = DATA_WIDTH_DEFAULT
)
(
  input  wire logic                  clk,
  input  wire logic                  rst_ni,
  input  wire logic                  data_req_i,
  input  wire dest_e                 dest_i,

  // Shared TCDM response
  input  wire logic                  sh_r_valid_i,
  input  wire logic [DATA_WIDTH-1:0] sh_r_rdata_i,

  // External response
  input  wire logic                  ext_r_valid_i,
  input  wire logic                  ext_r_opc_i,
  input  wire logic [DATA_WIDTH-1:0] ext_r_rdata_i,

  // Delayed peripheral response
  input  wire logic                  pe_r_valid_i,
  input  wire logic                  pe_r_opc_i,
  input  wire logic [DATA_WIDTH-1:0] pe_r_rdata_i,

  // Core response
  output logic                       data_r_valid_o,
  output logic                       data_r_opc_o,
  output logic [DATA_WIDTH-1:0]      data_r_rdata_o
);

  dest_e resp_dest_q;

  // Follows every request cycle so the held request keeps it stable
  always_ff @(posedge clk, negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      resp_dest_q <= SH;
    end
    else if (data_req_i)
    begin
      resp_dest_q <= dest_i;
    end
  end

  always_comb
  begin
    case (resp_dest_q)
      SH:
      begin
        data_r_valid_o = sh_r_valid_i;
        data_r_rdata_o = sh_r_rdata_i;
        data_r_opc_o   = 1'b0;  // TCDM never reports an error
      end
      EXT:
      begin
        data_r_valid_o = ext_r_valid_i;
        data_r_rdata_o = ext_r_rdata_i;
        data_r_opc_o   = ext_r_opc_i;
      end
      PE:
      begin
        data_r_valid_o = pe_r_valid_i;
        data_r_rdata_o = pe_r_rdata_i;
        data_r_opc_o   = pe_r_opc_i;
      end
      default:
      begin
        data_r_valid_o = 1'b0;
        data_r_rdata_o = sh_r_rdata_i;
        data_r_opc_o   = 1'b0;
      end
    endcase
  end

  // A returning response must find its own path still selected
  resp_routed_a: assert property (@(posedge clk) disable iff (!rst_ni)
    (sh_r_valid_i || ext_r_valid_i || pe_r_valid_i) |-> data_r_valid_o)
    else $error("resp_select: response arrived on a path that is not selected");

endmodule

`default_nettype wire

/* sim.f */
hw/core_demux_pkg.sv
hw/addr_decoder.sv
hw/req_router.sv
hw/periph_txn_fsm.sv
hw/resp_select.sv
hw/core_demux.sv
bench/tb_core_demux.sv
